// File: rename_pkg.sv
// widths, sizes, index and count types, and the two-view instruction word
`default_nettype none

package rename_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int N         = 2;                     // accept, dispatch and retire width
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 16;
    localparam int ROB_SZ    = 8;
    localparam int IB_SZ     = 8;
    localparam int FL_SZ     = PHYS_REGS - ARCH_REGS; // free regs after reset

    // index types
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_idx_t;
    typedef logic [$clog2(ROB_SZ)-1:0]    rob_idx_t;
    typedef logic [$clog2(IB_SZ)-1:0]     ib_idx_t;
    typedef logic [$clog2(FL_SZ)-1:0]     fl_idx_t;

    typedef logic [$clog2(N+1)-1:0]       count_t;  // 0 to N
    typedef logic [$clog2(IB_SZ+1)-1:0]   open_t;   // 0 to 8 free entries

    ////////////////////////////////////////////////////////////
    // instruction word, 16 bits, two formats
    ////////////////////////////////////////////////////////////

    localparam logic FMT_REG = 1'b1;
    localparam logic FMT_IMM = 1'b0;

    // register format
    typedef struct packed {
        logic       fmt;     // 1
        logic [2:0] opcode;
        arch_idx_t  dest;
        arch_idx_t  rs1;
        arch_idx_t  rs2;
        logic [2:0] pad;
    } inst_r_t;

    // immediate format, imm sits over rs2 and the pad bits
    typedef struct packed {
        logic       fmt;     // 0
        logic [2:0] opcode;
        arch_idx_t  dest;
        arch_idx_t  rs1;
        logic [5:0] imm;
    } inst_i_t;

    typedef union packed {
        inst_r_t reg_view;
        inst_i_t imm_view;
    } inst_word_u;

endpackage

`default_nettype wire

// File: inst_buffer.sv
// inst_buffer: circular instruction buffer, accepts up to N words, releases in order
`timescale 1ns/1ps
`default_nettype none

module inst_buffer (
    input  wire logic                                         clock,
    input  wire logic                                         reset,
    input  wire rename_pkg::inst_word_u [rename_pkg::N-1:0]   in_insts,
    input  wire rename_pkg::count_t                           in_count,     // words captured
    input  wire rename_pkg::count_t                           num_dispatch, // words leaving
    output rename_pkg::inst_word_u [rename_pkg::N-1:0]        head_insts,
    output rename_pkg::count_t                                head_count,
    output rename_pkg::open_t                                 open_entries
);
    import rename_pkg::*;

    inst_word_u buf_mem [IB_SZ];   // payload words
    ib_idx_t    head;              // oldest word
    ib_idx_t    tail;              // next free slot
    open_t      count;             // words held, 0 to IB_SZ

    ////////////////////////////////////////////////////////////
    // head view
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            head_insts[i] = buf_mem[ib_idx_t'(head + i)]; // wraps over the ring end
        end
        // at most N valid at the head
        if (count >= open_t'(N)) begin
            head_count = count_t'(N);
        end else begin
            head_count = count_t'(count);
        end
    end

    assign open_entries = open_t'(IB_SZ) - count; // source never offers more

    ////////////////////////////////////////////////////////////
    // writes and pointers
    ////////////////////////////////////////////////////////////

    // words land at tail in slot order
    always_ff @(posedge clock) begin
        for (int i = 0; i < N; i++) begin
            if (i < in_count) begin
                buf_mem[ib_idx_t'(tail + i)] <= in_insts[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ib_idx_t'(num_dispatch);
            tail  <= tail + ib_idx_t'(in_count);
            count <= count + open_t'(in_count) - open_t'(num_dispatch);
        end
    end

endmodule

`default_nettype wire

// File: dispatch.sv
// dispatch: decodes the buffer head words and picks the dispatch count
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input  wire rename_pkg::inst_word_u [rename_pkg::N-1:0] head_insts,
    input  wire rename_pkg::count_t                         head_count,
    input  wire rename_pkg::open_t                          rob_open,
    output rename_pkg::count_t                              num_dispatch,
    output rename_pkg::arch_idx_t [rename_pkg::N-1:0]       dest,
    output rename_pkg::arch_idx_t [rename_pkg::N-1:0]       rs1,
    output rename_pkg::arch_idx_t [rename_pkg::N-1:0]       rs2,
    output logic [rename_pkg::N-1:0]                        uses_rs2
);
    import rename_pkg::*;

    // dispatch count: min of valid words, width, rob space
    // free list depth tracks rob_open, so it needs no term here
    always_comb begin
        num_dispatch = head_count;
        if (num_dispatch > count_t'(N)) begin
            num_dispatch = count_t'(N);
        end
        if (rob_open < open_t'(num_dispatch)) begin
            num_dispatch = count_t'(rob_open); // rob back-pressure
        end
    end

    ////////////////////////////////////////////////////////////
    // per slot decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            // dest and rs1 sit at the same bits in both formats
            dest[i] = head_insts[i].reg_view.dest;
            rs1[i]  = head_insts[i].reg_view.rs1;
            if (head_insts[i].reg_view.fmt == FMT_REG) begin
                // register format, two sources
                rs2[i]      = head_insts[i].reg_view.rs2;
                uses_rs2[i] = 1'b1;
            end else begin
                // immediate format
                rs2[i]      = '0;   // imm bits are not a register name
                uses_rs2[i] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: free_list.sv
// free_list: circular queue of free physical registers, N pops and N pushes per cycle
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  wire logic                                   clock,
    input  wire logic                                   reset,
    input  wire rename_pkg::count_t                     rd_num,  // regs taken by dispatch
    input  wire rename_pkg::count_t                     wr_num,  // regs returned by retire
    input  wire rename_pkg::phys_idx_t [rename_pkg::N-1:0] wr_reg,
    output rename_pkg::phys_idx_t [rename_pkg::N-1:0]   rd_reg
);
    import rename_pkg::*;

    phys_idx_t entries [FL_SZ];  // free register numbers
    fl_idx_t   head;             // next to hand out
    fl_idx_t   tail;             // next return slot

    // queue is full after reset, so head == tail there
    // retire never returns more than dispatch took

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // always show the next N, dispatch takes rd_num of them
    always_comb begin
        for (int i = 0; i < N; i++) begin
            rd_reg[i] = entries[fl_idx_t'(head + i)];
        end
    end

    ////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FL_SZ; i++) begin
                entries[i] <= phys_idx_t'(ARCH_REGS + i); // 8 to 15 start free
            end
            head <= '0;
            tail <= '0;
        end else begin
            // returned regs readable next cycle
            for (int i = 0; i < N; i++) begin
                if (i < wr_num) begin
                    entries[fl_idx_t'(tail + i)] <= wr_reg[i];
                end
            end
            head <= head + fl_idx_t'(rd_num);
            tail <= tail + fl_idx_t'(wr_num);
        end
    end

endmodule

`default_nettype wire

// File: map_table.sv
// map_table: architectural to physical map with same-group bypass for two-wide rename
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  wire logic                                      clock,
    input  wire logic                                      reset,
    input  wire rename_pkg::count_t                        num_dispatch,
    input  wire rename_pkg::arch_idx_t [rename_pkg::N-1:0] dest,
    input  wire rename_pkg::arch_idx_t [rename_pkg::N-1:0] rs1,
    input  wire rename_pkg::arch_idx_t [rename_pkg::N-1:0] rs2,
    input  wire rename_pkg::phys_idx_t [rename_pkg::N-1:0] free_reg, // new dests
    output rename_pkg::phys_idx_t [rename_pkg::N-1:0]      prs1,
    output rename_pkg::phys_idx_t [rename_pkg::N-1:0]      prs2,
    output rename_pkg::phys_idx_t [rename_pkg::N-1:0]      t_old
);
    import rename_pkg::*;

    phys_idx_t rat [ARCH_REGS];  // current speculative mapping

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            prs1[i]  = rat[rs1[i]];
            prs2[i]  = rat[rs2[i]];
            t_old[i] = rat[dest[i]];  // freed when this one retires
            // older slots in this group override the table
            // ascending j so the youngest older writer wins
            for (int j = 0; j < i; j++) begin
                if (j < num_dispatch) begin
                    if (rs1[i] == dest[j]) begin
                        prs1[i] = free_reg[j];
                    end
                    if (rs2[i] == dest[j]) begin
                        prs2[i] = free_reg[j];
                    end
                    if (dest[i] == dest[j]) begin
                        t_old[i] = free_reg[j]; // returns slot 0's new reg
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // rename writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < ARCH_REGS; a++) begin
                rat[a] <= phys_idx_t'(a);  // identity map
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (i < num_dispatch) begin
                    rat[dest[i]] <= free_reg[i]; // later slot wins
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rob.sv
// rob: reorder buffer, in-order allocate, completion by index, in-order retire up to N
`timescale 1ns/1ps
`default_nettype none

module rob (
    input  wire logic                                      clock,
    input  wire logic                                      reset,
    input  wire rename_pkg::count_t                        num_dispatch,
    input  wire rename_pkg::arch_idx_t [rename_pkg::N-1:0] dest,
    input  wire rename_pkg::phys_idx_t [rename_pkg::N-1:0] t,      // new mapping
    input  wire rename_pkg::phys_idx_t [rename_pkg::N-1:0] t_old,  // mapping replaced
    input  wire logic                                      complete_valid,
    input  wire rename_pkg::rob_idx_t                      complete_idx,
    output rename_pkg::rob_idx_t [rename_pkg::N-1:0]       tail_tags,
    output rename_pkg::open_t                              open_entries,
    output rename_pkg::count_t                             num_retired,
    output rename_pkg::arch_idx_t [rename_pkg::N-1:0]      retire_arch,
    output rename_pkg::phys_idx_t [rename_pkg::N-1:0]      retire_t,
    output rename_pkg::phys_idx_t [rename_pkg::N-1:0]      retire_t_old
);
    import rename_pkg::*;

    // entry payload
    arch_idx_t dest_mem  [ROB_SZ];
    phys_idx_t t_mem     [ROB_SZ];
    phys_idx_t t_old_mem [ROB_SZ];

    logic [ROB_SZ-1:0] done;     // completion seen
    rob_idx_t          head;
    rob_idx_t          tail;
    open_t             count;    // entries in flight
    rob_idx_t [N-1:0]  head_idx;
    logic     [N-1:0]  ret_ok;   // slot i retires this cycle

    ////////////////////////////////////////////////////////////
    // allocation side
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            tail_tags[i] = rob_idx_t'(tail + i);  // tag of each dispatch slot
        end
    end

    assign open_entries = open_t'(ROB_SZ) - count; // registered, no retire credit

    ////////////////////////////////////////////////////////////
    // retire side
    ////////////////////////////////////////////////////////////

    always_comb begin
        num_retired = '0;
        for (int i = 0; i < N; i++) begin
            head_idx[i]     = rob_idx_t'(head + i);
            retire_arch[i]  = dest_mem[head_idx[i]];
            retire_t[i]     = t_mem[head_idx[i]];
            retire_t_old[i] = t_old_mem[head_idx[i]];
            // in order, stop at the first entry not yet done
            ret_ok[i] = (open_t'(i) < count) && done[head_idx[i]];
            if (i > 0) begin
                ret_ok[i] = ret_ok[i] && ret_ok[i-1];
            end
            if (ret_ok[i]) begin
                num_retired = num_retired + count_t'(1);
            end
        end
    end

    // payload written at allocation only
    always_ff @(posedge clock) begin
        for (int i = 0; i < N; i++) begin
            if (i < num_dispatch) begin
                dest_mem[tail_tags[i]]  <= dest[i];
                t_mem[tail_tags[i]]     <= t[i];
                t_old_mem[tail_tags[i]] <= t_old[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (i < num_dispatch) begin
                    done[tail_tags[i]] <= 1'b0;  // fresh entry
                end
            end
            if (complete_valid) begin
                done[complete_idx] <= 1'b1;     // retire-eligible next cycle
            end
            head  <= head + rob_idx_t'(num_retired);
            tail  <= tail + rob_idx_t'(num_dispatch);
            count <= count + open_t'(num_dispatch) - open_t'(num_retired);
        end
    end

endmodule

`default_nettype wire

// File: rename_core.sv
// rename_core: top level, buffer, dispatch, free list, map table and rob
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  wire logic                                         clock,
    input  wire logic                                         reset,
    input  wire rename_pkg::inst_word_u [rename_pkg::N-1:0]   in_insts,
    input  wire rename_pkg::count_t                           in_count,
    input  wire logic                                         complete_valid,
    input  wire rename_pkg::rob_idx_t                         complete_idx,
    output rename_pkg::open_t                                 ib_open,
    output logic [rename_pkg::N-1:0]                          dis_valid,
    output rename_pkg::rob_idx_t [rename_pkg::N-1:0]          dis_tag,
    output rename_pkg::phys_idx_t [rename_pkg::N-1:0]         dis_pdest,
    output rename_pkg::phys_idx_t [rename_pkg::N-1:0]         dis_prs1,
    output rename_pkg::phys_idx_t [rename_pkg::N-1:0]         dis_prs2,
    output logic [rename_pkg::N-1:0]                          dis_uses_rs2,
    output logic [rename_pkg::N-1:0]                          commit_valid,
    output rename_pkg::arch_idx_t [rename_pkg::N-1:0]         commit_arch,
    output rename_pkg::phys_idx_t [rename_pkg::N-1:0]         commit_phys
);
    import rename_pkg::*;

    ////////////////////////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////////////////////////

    inst_word_u [N-1:0] ib_insts;      // buffer head
    count_t             ib_count;
    count_t             num_dis;       // one count drives every block
    count_t             num_retired;
    open_t              rob_open;
    arch_idx_t [N-1:0]  dis_dest;
    arch_idx_t [N-1:0]  dis_rs1;
    arch_idx_t [N-1:0]  dis_rs2;
    phys_idx_t [N-1:0]  t_old;         // map table to rob
    phys_idx_t [N-1:0]  ret_t_old;     // rob back to free list

    always_comb begin
        for (int i = 0; i < N; i++) begin
            dis_valid[i]    = i < num_dis;
            commit_valid[i] = i < num_retired;
        end
    end

    inst_buffer u_ib (
        .clock(clock), .reset(reset),
        .in_insts(in_insts), .in_count(in_count), .num_dispatch(num_dis),
        .head_insts(ib_insts), .head_count(ib_count), .open_entries(ib_open)
    );

    dispatch u_dis (
        .head_insts(ib_insts), .head_count(ib_count), .rob_open(rob_open),
        .num_dispatch(num_dis), .dest(dis_dest), .rs1(dis_rs1), .rs2(dis_rs2),
        .uses_rs2(dis_uses_rs2)
    );

    free_list u_fl (
        .clock(clock), .reset(reset),
        .rd_num(num_dis), .wr_num(num_retired), .wr_reg(ret_t_old),
        .rd_reg(dis_pdest)   // new physical dests
    );

    map_table u_mt (
        .clock(clock), .reset(reset),
        .num_dispatch(num_dis), .dest(dis_dest), .rs1(dis_rs1), .rs2(dis_rs2),
        .free_reg(dis_pdest), .prs1(dis_prs1), .prs2(dis_prs2), .t_old(t_old)
    );

    rob u_rob (
        .clock(clock), .reset(reset),
        .num_dispatch(num_dis), .dest(dis_dest), .t(dis_pdest), .t_old(t_old),
        .complete_valid(complete_valid), .complete_idx(complete_idx),
        .tail_tags(dis_tag), .open_entries(rob_open), .num_retired(num_retired),
        .retire_arch(commit_arch), .retire_t(commit_phys), .retire_t_old(ret_t_old)
    );

endmodule

`default_nettype wire

// File: rename_core_asserts.sv
// rename_core_asserts: shadow program-order model and concurrent checks, bound to rename_core
`timescale 1ns/1ps
`default_nettype none

module rename_core_asserts (
    input wire logic                                       clock,
    input wire logic                                       reset,
    input wire rename_pkg::inst_word_u [rename_pkg::N-1:0] in_insts,
    input wire rename_pkg::count_t                         in_count,
    input wire logic                                       complete_valid,
    input wire rename_pkg::rob_idx_t                       complete_idx,
    input wire rename_pkg::open_t                          ib_open,
    input wire logic [rename_pkg::N-1:0]                   dis_valid,
    input wire rename_pkg::rob_idx_t [rename_pkg::N-1:0]   dis_tag,
    input wire rename_pkg::phys_idx_t [rename_pkg::N-1:0]  dis_pdest,
    input wire rename_pkg::phys_idx_t [rename_pkg::N-1:0]  dis_prs1,
    input wire rename_pkg::phys_idx_t [rename_pkg::N-1:0]  dis_prs2,
    input wire logic [rename_pkg::N-1:0]                   dis_uses_rs2,
    input wire logic [rename_pkg::N-1:0]                   commit_valid,
    input wire rename_pkg::arch_idx_t [rename_pkg::N-1:0]  commit_arch,
    input wire rename_pkg::phys_idx_t [rename_pkg::N-1:0]  commit_phys
);
    import rename_pkg::*;

    int unsigned          fail_count = 0;   // polled by the testbench
    inst_word_u           words [64];       // accepted words by sequence number
    int unsigned          acc_n;            // words accepted so far
    int unsigned          dis_n;            // words dispatched so far
    int unsigned          ret_n;            // entries retired so far
    phys_idx_t            amap [ARCH_REGS]; // shadow arch map
    logic [PHYS_REGS-1:0] busy;             // mapped, or old mapping not yet retired
    arch_idx_t            rec_arch  [ROB_SZ];
    phys_idx_t            rec_t     [ROB_SZ];
    phys_idx_t            rec_t_old [ROB_SZ];
    logic [ROB_SZ-1:0]    done;             // completion seen, by tag

    int unsigned          exp_dis;
    logic                 chain;
    inst_word_u [N-1:0]   head_w;
    logic      [N-1:0]    exp_fmt;
    logic      [N-1:0]    exp_valid;
    logic      [N-1:0]    exp_commit;
    arch_idx_t [N-1:0]    e_dest;
    arch_idx_t [N-1:0]    e_rs1;
    arch_idx_t [N-1:0]    e_rs2;
    phys_idx_t [N-1:0]    exp_prs1;
    phys_idx_t [N-1:0]    exp_prs2;
    phys_idx_t [N-1:0]    exp_t_old;

    ////////////////////////////////////////////////////////////
    // expected values from the shadow state
    ////////////////////////////////////////////////////////////

    always_comb begin
        exp_dis = acc_n - dis_n;                 // words waiting in the buffer
        if (exp_dis > N) begin
            exp_dis = N;
        end
        if (exp_dis > ROB_SZ - (dis_n - ret_n)) begin
            exp_dis = ROB_SZ - (dis_n - ret_n);  // rob space
        end
        chain = 1'b1;
        for (int i = 0; i < N; i++) begin
            head_w[i]    = words[(dis_n + i) % 64];
            exp_fmt[i]   = head_w[i].reg_view.fmt;
            exp_valid[i] = i < exp_dis;
            e_dest[i]    = head_w[i].reg_view.dest;  // same bits in both views
            e_rs1[i]     = head_w[i].reg_view.rs1;
            if (exp_fmt[i]) begin
                e_rs2[i] = head_w[i].reg_view.rs2;
            end else begin
                e_rs2[i] = '0;                   // no second source
            end
            exp_prs1[i]  = amap[e_rs1[i]];
            exp_prs2[i]  = amap[e_rs2[i]];
            exp_t_old[i] = amap[e_dest[i]];
            // retire in order, stop at the first one not done
            chain = chain && (ret_n + i < dis_n) && done[rob_idx_t'(ret_n + i)];
            exp_commit[i] = chain;
        end
        // slot 1 sees slot 0's new mapping in the same group
        if (exp_dis == N) begin
            if (e_rs1[1] == e_dest[0]) begin
                exp_prs1[1] = dis_pdest[0];
            end
            if (e_rs2[1] == e_dest[0]) begin
                exp_prs2[1] = dis_pdest[0];
            end
            if (e_dest[1] == e_dest[0]) begin
                exp_t_old[1] = dis_pdest[0];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // shadow update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            acc_n <= 0;
            dis_n <= 0;
            ret_n <= 0;
            done  <= '0;
            for (int a = 0; a < ARCH_REGS; a++) begin
                amap[a] <= phys_idx_t'(a);
            end
            for (int p = 0; p < PHYS_REGS; p++) begin
                busy[p] <= p < ARCH_REGS;        // identity map holds 0 to 7
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (i < in_count) begin
                    words[(acc_n + i) % 64] <= in_insts[i];
                end
                if (commit_valid[i]) begin
                    busy[rec_t_old[rob_idx_t'(ret_n + i)]] <= 1'b0; // old mapping dead
                end
                if (dis_valid[i]) begin
                    amap[e_dest[i]]   <= dis_pdest[i];  // slot 1 written last
                    busy[dis_pdest[i]] <= 1'b1;
                    rec_arch[rob_idx_t'(dis_n + i)]  <= e_dest[i];
                    rec_t[rob_idx_t'(dis_n + i)]     <= dis_pdest[i];
                    rec_t_old[rob_idx_t'(dis_n + i)] <= exp_t_old[i];
                    done[rob_idx_t'(dis_n + i)]      <= 1'b0;
                end
            end
            if (complete_valid) begin
                done[complete_idx] <= 1'b1;
            end
            acc_n <= acc_n + in_count;
            dis_n <= dis_n + $countones(dis_valid);
            ret_n <= ret_n + $countones(commit_valid);
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_reset: assert property (@(posedge clock) $fell(reset) |->
        dis_valid == '0 && commit_valid == '0 && ib_open == open_t'(IB_SZ))
        else begin
            $error("Error after reset dis_valid=%h commit_valid=%h ib_open=%h",
                $sampled(dis_valid), $sampled(commit_valid), $sampled(ib_open));
            fail_count++;
        end

    a_ib_open: assert property (@(posedge clock) disable iff (reset)
        ib_open == open_t'(IB_SZ - (acc_n - dis_n)))
        else begin
            $error("Error ib_open got %h expected %h", $sampled(ib_open),
                $sampled(open_t'(IB_SZ - (acc_n - dis_n))));
            fail_count++;
        end

    a_dis_count: assert property (@(posedge clock) disable iff (reset) dis_valid == exp_valid)
        else begin
            $error("Error dis_valid got %h expected %h", $sampled(dis_valid),
                $sampled(exp_valid));
            fail_count++;
        end

    // rob full with nothing done, no slot may go
    a_rob_full: assert property (@(posedge clock) disable iff (reset)
        (dis_n - ret_n == ROB_SZ) |-> dis_valid == '0)
        else begin
            $error("dispatch happened while the reorder buffer was full");
            fail_count++;
        end

    a_pdest_pair: assert property (@(posedge clock) disable iff (reset)
        dis_valid[1] |-> dis_pdest[0] != dis_pdest[1])
        else begin
            $error("Error dis_pdest both slots got %h", $sampled(dis_pdest[0]));
            fail_count++;
        end

    a_commit: assert property (@(posedge clock) disable iff (reset) commit_valid == exp_commit)
        else begin
            $error("Error commit_valid got %h expected %h", $sampled(commit_valid),
                $sampled(exp_commit));
            fail_count++;
        end

    for (genvar i = 0; i < N; i++) begin : g_slot
        a_fmt: assert property (@(posedge clock) disable iff (reset)
            dis_valid[i] |-> dis_uses_rs2[i] == exp_fmt[i])
            else begin
                $error("Error dis_uses_rs2[%0d] got %h expected %h", i,
                    $sampled(dis_uses_rs2[i]), $sampled(exp_fmt[i]));
                fail_count++;
            end
        a_tag: assert property (@(posedge clock) disable iff (reset)
            dis_valid[i] |-> dis_tag[i] == rob_idx_t'(dis_n + i))
            else begin
                $error("Error dis_tag[%0d] got %h expected %h", i, $sampled(dis_tag[i]),
                    $sampled(rob_idx_t'(dis_n + i)));
                fail_count++;
            end
        a_prs1: assert property (@(posedge clock) disable iff (reset)
            dis_valid[i] |-> dis_prs1[i] == exp_prs1[i])
            else begin
                $error("Error dis_prs1[%0d] got %h expected %h", i, $sampled(dis_prs1[i]),
                    $sampled(exp_prs1[i]));
                fail_count++;
            end
        a_prs2: assert property (@(posedge clock) disable iff (reset)
            dis_valid[i] && exp_fmt[i] |-> dis_prs2[i] == exp_prs2[i])
            else begin
                $error("Error dis_prs2[%0d] got %h expected %h", i, $sampled(dis_prs2[i]),
                    $sampled(exp_prs2[i]));
                fail_count++;
            end
        a_pdest_free: assert property (@(posedge clock) disable iff (reset)
            dis_valid[i] |-> !busy[dis_pdest[i]])
            else begin
                $error("Error dis_pdest[%0d] got %h which is still in use", i,
                    $sampled(dis_pdest[i]));
                fail_count++;
            end
        a_commit_fields: assert property (@(posedge clock) disable iff (reset)
            commit_valid[i] |-> commit_arch[i] == rec_arch[rob_idx_t'(ret_n + i)]
                && commit_phys[i] == rec_t[rob_idx_t'(ret_n + i)])
            else begin
                $error("Error commit_arch[%0d]/commit_phys[%0d] got %h/%h expected %h/%h", i, i,
                    $sampled(commit_arch[i]), $sampled(commit_phys[i]),
                    $sampled(rec_arch[rob_idx_t'(ret_n + i)]),
                    $sampled(rec_t[rob_idx_t'(ret_n + i)]));
                fail_count++;
            end
    end

endmodule

`default_nettype wire

// File: rename_core_tb.sv
// rename_core_tb: clock, reset, random stimulus, completion driver, watchdog and run result
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb;
    import rename_pkg::*;

    localparam int TOTAL   = 400;            // words offered over the run
    localparam int TIMEOUT = TOTAL * 20 * 8; // ns, 20 cycles per word

    logic                clock;
    logic                reset;
    inst_word_u [N-1:0]  in_insts;
    count_t              in_count;
    logic                complete_valid;
    rob_idx_t            complete_idx;
    open_t               ib_open;
    logic      [N-1:0]   dis_valid;
    rob_idx_t  [N-1:0]   dis_tag;
    phys_idx_t [N-1:0]   dis_pdest;
    phys_idx_t [N-1:0]   dis_prs1;
    phys_idx_t [N-1:0]   dis_prs2;
    logic      [N-1:0]   dis_uses_rs2;
    logic      [N-1:0]   commit_valid;
    arch_idx_t [N-1:0]   commit_arch;
    phys_idx_t [N-1:0]   commit_phys;

    rob_idx_t pending [$];   // dispatched tags waiting for completion
    int       words_left;    // words still to offer
    int       committed;     // retirements seen
    int       pause_left;    // cycles left in a completion gap

    rename_core DUT (.*);

    bind rename_core rename_core_asserts u_asserts (.*);

    always #4 clock = ~clock;  // 8 ns period

    // random format, opcode and register fields
    function automatic inst_word_u random_word();
        return inst_word_u'(16'($urandom));
    endfunction

    // one cycle: sample at the falling edge, drive 1 ns after the rising edge
    // mode 0 random, mode 1 stall with no completions, mode 2 drain
    task automatic run_cycle(input int mode);
        int n;
        int k;
        @(negedge clock);
        for (int i = 0; i < N; i++) begin
            if (dis_valid[i]) begin
                pending.push_back(dis_tag[i]);  // dispatches at the next edge
            end
            if (commit_valid[i]) begin
                committed++;
            end
        end
        @(posedge clock);
        #1;
        n = (mode == 1) ? N : $urandom_range(N, 0);
        if (n > int'(ib_open)) begin
            n = int'(ib_open);                  // never more than ib_open
        end
        if (n > words_left) begin
            n = words_left;
        end
        for (int i = 0; i < N; i++) begin
            in_insts[i] = random_word();
        end
        in_count   = count_t'(n);
        words_left = words_left - n;
        complete_valid = 1'b0;
        if (pause_left > 0) begin
            pause_left--;
        end else if (mode == 0 && $urandom_range(15, 0) == 0) begin
            pause_left = $urandom_range(12, 3);  // start a gap
        end
        if (mode != 1 && (pause_left == 0 || mode == 2) && pending.size() > 0
                && (mode == 2 || $urandom_range(3, 0) != 0)) begin
            k = $urandom_range(pending.size() - 1, 0);  // any outstanding tag
            complete_valid = 1'b1;
            complete_idx   = pending[k];
            pending.delete(k);
        end
    endtask

    // stop at the first failed check
    always @(negedge clock) begin
        if (DUT.u_asserts.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "a checker assertion failed");
        end
    end

    initial begin
        #(TIMEOUT);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout, the run did not finish within %0d ns", TIMEOUT);
    end

    initial begin
        void'($urandom(32'h4f0c));
        clock          = 1'b0;
        reset          = 1'b1;
        in_insts       = '0;
        in_count       = '0;
        complete_valid = 1'b0;
        complete_idx   = '0;
        words_left     = TOTAL;
        committed      = 0;
        pause_left     = 0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        repeat (120) run_cycle(0);
        repeat (24) run_cycle(1);    // rob fills, then the buffer
        while (words_left > 0) begin
            run_cycle(0);
        end
        while (committed < TOTAL) begin
            run_cycle(2);            // complete all that is left
        end
        repeat (2) @(negedge clock);

        if (DUT.u_asserts.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "checker reported failures");
        end
    end

endmodule

`default_nettype wire

// File: rename_core.f
rename_pkg.sv
inst_buffer.sv
dispatch.sv
free_list.sv
map_table.sv
rob.sv
rename_core.sv
rename_core_asserts.sv
rename_core_tb.sv

// File: Bender.yml
package:
  name: rename_core

sources:
  - rename_pkg.sv
  - inst_buffer.sv
  - dispatch.sv
  - free_list.sv
  - map_table.sv
  - rob.sv
  - rename_core.sv
  - target: test
    files:
      - rename_core_asserts.sv
      - rename_core_tb.sv
